// File: Bender.yml
package:
  name: fsab_memory

sources:
  - logic/fsab_mem_pkg.sv
  - logic/sync_fifo.sv
  - logic/fsab_req_intake.sv
  - logic/mig_cmd_issue.sv
  - logic/fsab_resp_return.sv
  - logic/fsab_memory.sv
  - target: simulation
    files:
      - verif/mig_app_model.sv
      - verif/fsab_memory_tb.sv

// File: fsab_memory.f
logic/fsab_mem_pkg.sv
logic/sync_fifo.sv
logic/fsab_req_intake.sv
logic/mig_cmd_issue.sv
logic/fsab_resp_return.sv
logic/fsab_memory.sv
verif/mig_app_model.sv
verif/fsab_memory_tb.sv

// File: logic/fsab_mem_pkg.sv
package fsab_mem_pkg;

	// Host bus
	localparam int FSAB_DATA_W = 64;
	localparam int FSAB_MASK_W = 8;     // Set bit means byte not written
	localparam int FSAB_DID_W = 4;
	localparam int FSAB_ADDR_W = 31;
	localparam int FSAB_LEN_W = 4;
	localparam int FSAB_LEN_MAX = 4;    // Beats in the largest request
	localparam int FSAB_REQ_W = 1;

	localparam logic [FSAB_REQ_W-1:0] FSAB_READ = 1'b0;
	localparam logic [FSAB_REQ_W-1:0] FSAB_WRITE = 1'b1;

	localparam int FSAB_INITIAL_CREDITS = 4;

	// DDR2 controller application port
	localparam int MIG_WORD_W = 2 * FSAB_DATA_W;
	localparam int MIG_MASK_W = 2 * FSAB_MASK_W;
	localparam int MIG_CMD_W = 3;

	localparam logic [MIG_CMD_W-1:0] MIG_WRITE = 3'd0;
	localparam logic [MIG_CMD_W-1:0] MIG_READ = 3'd1;

	localparam int MIG_BURST_WORDS = 2; // Words returned per read command

	// Request header {mode, did, subdid, addr, len}
	localparam int IRFIF_W = FSAB_REQ_W + 2 * FSAB_DID_W + FSAB_ADDR_W + FSAB_LEN_W;

	// Packed beat pair {data_hi, mask_hi, data_lo, mask_lo}
	localparam int IDFIF_W = 2 * (FSAB_DATA_W + FSAB_MASK_W);

	// Response header {did, subdid, len}
	localparam int ORFIF_W = 2 * FSAB_DID_W + FSAB_LEN_W;

endpackage

// File: logic/fsab_memory.sv
`timescale 1ns/100ps

module fsab_memory import fsab_mem_pkg::*; #(
	parameter int CREDITS = FSAB_INITIAL_CREDITS
) (
	input  logic                   clk0_tb,
	input  logic                   rst0_tb,
	// Host requests
	input  logic                   fsabo_valid,
	input  logic [FSAB_REQ_W-1:0]  fsabo_mode,
	input  logic [FSAB_DID_W-1:0]  fsabo_did,
	input  logic [FSAB_DID_W-1:0]  fsabo_subdid,
	input  logic [FSAB_ADDR_W-1:0] fsabo_addr,
	input  logic [FSAB_LEN_W-1:0]  fsabo_len,
	input  logic [FSAB_DATA_W-1:0] fsabo_data,
	input  logic [FSAB_MASK_W-1:0] fsabo_mask,
	output logic                   fsabo_credit,
	// Host responses
	output logic                   fsabi_valid,
	output logic [FSAB_DID_W-1:0]  fsabi_did,
	output logic [FSAB_DID_W-1:0]  fsabi_subdid,
	output logic [FSAB_DATA_W-1:0] fsabi_data,
	// DDR2 controller application port
	input  logic                   phy_init_done,
	output logic                   app_af_wren,
	output logic [MIG_CMD_W-1:0]   app_af_cmd,
	output logic [FSAB_ADDR_W-1:0] app_af_addr,
	input  logic                   app_af_afull,
	output logic                   app_wdf_wren,
	output logic [MIG_WORD_W-1:0]  app_wdf_data,
	output logic [MIG_MASK_W-1:0]  app_wdf_mask_data,
	input  logic                   app_wdf_afull,
	input  logic                   rd_data_valid,
	input  logic [MIG_WORD_W-1:0]  rd_data_fifo_out
);

	logic [IRFIF_W-1:0] irfif_rdat;
	logic [IDFIF_W-1:0] idfif_rdat;
	logic               have_req;
	logic               irfif_rd;
	logic               idfif_rd;
	logic               orfif_wr;
	logic [ORFIF_W-1:0] orfif_wdat;
	logic               ofif_credit;

	fsab_req_intake #(.CREDITS(CREDITS)) intake (
		.clk0_tb      (clk0_tb),
		.rst0_tb      (rst0_tb),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.irfif_rd     (irfif_rd),
		.idfif_rd     (idfif_rd),
		.irfif_rdat   (irfif_rdat),
		.idfif_rdat   (idfif_rdat),
		.have_req     (have_req)
	);

	mig_cmd_issue #(.CREDITS(CREDITS)) issue (
		.clk0_tb           (clk0_tb),
		.rst0_tb           (rst0_tb),
		.irfif_rdat        (irfif_rdat),
		.idfif_rdat        (idfif_rdat),
		.have_req          (have_req),
		.phy_init_done     (phy_init_done),
		.app_af_afull      (app_af_afull),
		.app_wdf_afull     (app_wdf_afull),
		.ofif_credit       (ofif_credit),
		.irfif_rd          (irfif_rd),
		.idfif_rd          (idfif_rd),
		.fsabo_credit      (fsabo_credit),
		.app_af_wren       (app_af_wren),
		.app_af_cmd        (app_af_cmd),
		.app_af_addr       (app_af_addr),
		.app_wdf_wren      (app_wdf_wren),
		.app_wdf_data      (app_wdf_data),
		.app_wdf_mask_data (app_wdf_mask_data),
		.orfif_wr          (orfif_wr),
		.orfif_wdat        (orfif_wdat)
	);

	fsab_resp_return #(.CREDITS(CREDITS)) resp (
		.clk0_tb          (clk0_tb),
		.rst0_tb          (rst0_tb),
		.orfif_wr         (orfif_wr),
		.orfif_wdat       (orfif_wdat),
		.rd_data_valid    (rd_data_valid),
		.rd_data_fifo_out (rd_data_fifo_out),
		.fsabi_valid      (fsabi_valid),
		.fsabi_did        (fsabi_did),
		.fsabi_subdid     (fsabi_subdid),
		.fsabi_data       (fsabi_data),
		.ofif_credit      (ofif_credit)
	);

endmodule

// File: logic/fsab_req_intake.sv
`timescale 1ns/100ps

module fsab_req_intake import fsab_mem_pkg::*; #(
	parameter int CREDITS = FSAB_INITIAL_CREDITS
) (
	input  logic                   clk0_tb,
	input  logic                   rst0_tb,
	input  logic                   fsabo_valid,
	input  logic [FSAB_REQ_W-1:0]  fsabo_mode,
	input  logic [FSAB_DID_W-1:0]  fsabo_did,
	input  logic [FSAB_DID_W-1:0]  fsabo_subdid,
	input  logic [FSAB_ADDR_W-1:0] fsabo_addr,
	input  logic [FSAB_LEN_W-1:0]  fsabo_len,
	input  logic [FSAB_DATA_W-1:0] fsabo_data,
	input  logic [FSAB_MASK_W-1:0] fsabo_mask,
	input  logic                   irfif_rd,
	input  logic                   idfif_rd,
	output logic [IRFIF_W-1:0]     irfif_rdat,
	output logic [IDFIF_W-1:0]     idfif_rdat,
	output logic                   have_req
);

	localparam int QW = $clog2(CREDITS + 1);

	logic [FSAB_LEN_W-1:0]  len_rem;      // Beats still due in current write
	logic                   first_beat;
	logic                   last_beat;
	logic                   have_lo;      // Low half of a pair is waiting
	logic [FSAB_DATA_W-1:0] lo_data;
	logic [FSAB_MASK_W-1:0] lo_mask;
	logic                   pair_wr;
	logic [IDFIF_W-1:0]     pair_dat;
	logic                   req_complete; // Last pair of a request queued
	logic [QW-1:0]          reqs_queued;

	assign first_beat = (len_rem == '0);

	// A read carries one beat, which still takes a slot in the data queue
	assign last_beat = first_beat ? (fsabo_mode == FSAB_READ || fsabo_len <= 1)
	                              : (len_rem == 1);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			len_rem <= '0;
			have_lo <= 1'b0;
			pair_wr <= 1'b0;
			req_complete <= 1'b0;
		end else begin
			pair_wr <= fsabo_valid && (have_lo || last_beat);
			req_complete <= fsabo_valid && last_beat;
			if (fsabo_valid) begin
				if (first_beat && !last_beat)
					len_rem <= fsabo_len - 1'b1;   // Header beat of a long write
				else if (!first_beat)
					len_rem <= len_rem - 1'b1;
				have_lo <= !have_lo && !last_beat;
			end
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (fsabo_valid) begin
			lo_data <= fsabo_data;
			lo_mask <= fsabo_mask;
			if (have_lo)
				pair_dat <= {fsabo_data, fsabo_mask, lo_data, lo_mask};
			else
				pair_dat <= {{FSAB_DATA_W{1'b0}}, {FSAB_MASK_W{1'b1}},   // Odd beat padded high
				             fsabo_data, fsabo_mask};
		end
	end

	// Requests with header and all data queued
	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb)
			reqs_queued <= '0;
		else
			reqs_queued <= reqs_queued + QW'(req_complete) - QW'(irfif_rd);
	end

	assign have_req = (reqs_queued != '0);

	sync_fifo #(
		.DEPTH (CREDITS),
		.WIDTH (IRFIF_W)
	) irfif (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.wr_en   (fsabo_valid && first_beat),
		.rd_en   (irfif_rd),
		.wr_dat  ({fsabo_mode, fsabo_did, fsabo_subdid, fsabo_addr, fsabo_len}),
		.rd_dat  (irfif_rdat),
		.empty   ()
	);

	sync_fifo #(
		.DEPTH (CREDITS * FSAB_LEN_MAX / 2),   // Two beats per entry
		.WIDTH (IDFIF_W)
	) idfif (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.wr_en   (pair_wr),
		.rd_en   (idfif_rd),
		.wr_dat  (pair_dat),
		.rd_dat  (idfif_rdat),
		.empty   ()
	);

endmodule

// File: logic/fsab_resp_return.sv
`timescale 1ns/100ps

module fsab_resp_return import fsab_mem_pkg::*; #(
	parameter int CREDITS = FSAB_INITIAL_CREDITS
) (
	input  logic                   clk0_tb,
	input  logic                   rst0_tb,
	input  logic                   orfif_wr,
	input  logic [ORFIF_W-1:0]     orfif_wdat,
	input  logic                   rd_data_valid,
	input  logic [MIG_WORD_W-1:0]  rd_data_fifo_out,
	output logic                   fsabi_valid,
	output logic [FSAB_DID_W-1:0]  fsabi_did,
	output logic [FSAB_DID_W-1:0]  fsabi_subdid,
	output logic [FSAB_DATA_W-1:0] fsabi_data,
	output logic                   ofif_credit
);

	localparam int DDEPTH = CREDITS * MIG_BURST_WORDS;
	localparam int AW = $clog2(DDEPTH + 1);

	logic                  orfif_rd;
	logic                  orfif_empty;
	logic [ORFIF_W-1:0]    orfif_rdat;
	logic                  hdr_q;         // First beat of a response
	logic [FSAB_LEN_W-1:0] resp_len;
	logic [FSAB_LEN_W-1:0] beats_rem;
	logic                  more_beats;
	logic                  hi_half;       // Beat parity
	logic                  odfif_rd;
	logic [MIG_WORD_W-1:0] odfif_rdat;
	logic [AW-1:0]         words_avail;   // Read words not yet popped

	assign {fsabi_did, fsabi_subdid, resp_len} = orfif_rdat;

	assign more_beats = (hdr_q && resp_len > 1) || beats_rem > 1;

	// Start only with a whole burst on hand
	assign orfif_rd = !orfif_empty && !more_beats && words_avail >= MIG_BURST_WORDS;
	assign odfif_rd = orfif_rd || (more_beats && hi_half);

	assign fsabi_valid = hdr_q || (beats_rem != '0);
	assign fsabi_data = hi_half ? odfif_rdat[MIG_WORD_W-1:FSAB_DATA_W]
	                            : odfif_rdat[FSAB_DATA_W-1:0];
	assign ofif_credit = fsabi_valid && !more_beats;

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			hdr_q <= 1'b0;
			beats_rem <= '0;
			hi_half <= 1'b0;
			words_avail <= '0;
		end else begin
			hdr_q <= orfif_rd;
			if (hdr_q)
				beats_rem <= resp_len - 1'b1;
			else if (beats_rem != '0)
				beats_rem <= beats_rem - 1'b1;
			hi_half <= fsabi_valid ? !hi_half : 1'b0;
			words_avail <= words_avail + AW'(rd_data_valid) - AW'(odfif_rd);
		end
	end

	sync_fifo #(
		.DEPTH (CREDITS),
		.WIDTH (ORFIF_W)
	) orfif (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.wr_en   (orfif_wr),
		.rd_en   (orfif_rd),
		.wr_dat  (orfif_wdat),
		.rd_dat  (orfif_rdat),
		.empty   (orfif_empty)
	);

	sync_fifo #(
		.DEPTH (DDEPTH),
		.WIDTH (MIG_WORD_W)
	) odfif (
		.clk0_tb (clk0_tb),
		.rst0_tb (rst0_tb),
		.wr_en   (rd_data_valid),
		.rd_en   (odfif_rd),
		.wr_dat  (rd_data_fifo_out),
		.rd_dat  (odfif_rdat),
		.empty   ()
	);

endmodule

// File: logic/mig_cmd_issue.sv
`timescale 1ns/100ps

module mig_cmd_issue import fsab_mem_pkg::*; #(
	parameter int CREDITS = FSAB_INITIAL_CREDITS
) (
	input  logic                   clk0_tb,
	input  logic                   rst0_tb,
	input  logic [IRFIF_W-1:0]     irfif_rdat,
	input  logic [IDFIF_W-1:0]     idfif_rdat,
	input  logic                   have_req,
	input  logic                   phy_init_done,
	input  logic                   app_af_afull,
	input  logic                   app_wdf_afull,
	input  logic                   ofif_credit,
	output logic                   irfif_rd,
	output logic                   idfif_rd,
	output logic                   fsabo_credit,
	output logic                   app_af_wren,
	output logic [MIG_CMD_W-1:0]   app_af_cmd,
	output logic [FSAB_ADDR_W-1:0] app_af_addr,
	output logic                   app_wdf_wren,
	output logic [MIG_WORD_W-1:0]  app_wdf_data,
	output logic [MIG_MASK_W-1:0]  app_wdf_mask_data,
	output logic                   orfif_wr,
	output logic [ORFIF_W-1:0]     orfif_wdat
);

	localparam int CW = $clog2(CREDITS + 1);

	logic [FSAB_REQ_W-1:0]  hdr_mode;
	logic [FSAB_DID_W-1:0]  hdr_did;
	logic [FSAB_DID_W-1:0]  hdr_subdid;
	logic [FSAB_ADDR_W-1:0] hdr_addr;
	logic [FSAB_LEN_W-1:0]  hdr_len;
	logic [FSAB_LEN_W-1:0]  word_cnt;     // Controller words in request
	logic                   is_write;
	logic [FSAB_DATA_W-1:0] data_hi;
	logic [FSAB_MASK_W-1:0] mask_hi;
	logic [FSAB_DATA_W-1:0] data_lo;
	logic [FSAB_MASK_W-1:0] mask_lo;
	logic                   irfif_rd_q;   // Header visible on irfif_rdat
	logic                   idfif_rd_q;   // Word visible on idfif_rdat
	logic [FSAB_LEN_W-1:0]  words_rem;
	logic                   stall;
	logic                   active;       // Write still needs data pops
	logic [CW-1:0]          resp_credits;

	assign {hdr_mode, hdr_did, hdr_subdid, hdr_addr, hdr_len} = irfif_rdat;
	assign {data_hi, mask_hi, data_lo, mask_lo} = idfif_rdat;

	assign is_write = (hdr_mode == FSAB_WRITE);
	assign word_cnt = hdr_len[FSAB_LEN_W-1:1] + hdr_len[0];   // Beats / 2, rounded up

	// Hold the command on afull, or on a read with no room for its response
	assign stall = (irfif_rd_q && (app_af_afull || (!is_write && resp_credits == '0)))
	            || (idfif_rd_q && is_write && app_wdf_afull);

	assign active = is_write && ((irfif_rd_q && word_cnt > 1) || words_rem > 1);

	assign irfif_rd = !stall && have_req && !active && phy_init_done
	               && !app_af_afull && !app_wdf_afull;
	assign idfif_rd = !stall && (irfif_rd || active);   // Every header pops a pair

	assign app_af_wren = irfif_rd_q && !stall;
	assign app_af_cmd = is_write ? MIG_WRITE : MIG_READ;
	assign app_af_addr = hdr_addr;
	assign app_wdf_wren = is_write && idfif_rd_q && !stall;
	assign app_wdf_data = {data_hi, data_lo};
	assign app_wdf_mask_data = {mask_hi, mask_lo};

	// Last queued word of the request leaves
	assign fsabo_credit = (app_af_wren && (!is_write || word_cnt <= 1))
	                   || (app_wdf_wren && !irfif_rd_q && words_rem == 1);

	assign orfif_wr = app_af_wren && !is_write;
	assign orfif_wdat = {hdr_did, hdr_subdid, hdr_len};

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			irfif_rd_q <= 1'b0;
			idfif_rd_q <= 1'b0;
			words_rem <= '0;
			resp_credits <= CW'(CREDITS);
		end else begin
			if (!stall) begin
				irfif_rd_q <= irfif_rd;
				idfif_rd_q <= idfif_rd;
			end
			if (app_af_wren && is_write)
				words_rem <= (word_cnt > 1) ? word_cnt - 1'b1 : '0;
			else if (app_wdf_wren)
				words_rem <= words_rem - 1'b1;
			resp_credits <= resp_credits - CW'(orfif_wr) + CW'(ofif_credit);
		end
	end

endmodule

// File: logic/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 8
) (
	input  logic             clk0_tb,
	input  logic             rst0_tb,
	input  logic             wr_en,
	input  logic             rd_en,
	input  logic [WIDTH-1:0] wr_dat,
	output logic [WIDTH-1:0] rd_dat,
	output logic             empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count;    // Entries held

	assign empty = (count == '0);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CW'(wr_en) - CW'(rd_en);
		end
	end

	// Storage and read port
	always_ff @(posedge clk0_tb) begin
		if (wr_en)
			mem[wr_ptr] <= wr_dat;
		if (rd_en)
			rd_dat <= mem[rd_ptr];   // Valid the cycle after rd_en
	end

endmodule

// File: verif/fsab_memory_tb.sv
`timescale 1ns/100ps

module fsab_memory_tb import fsab_mem_pkg::*; #(
	parameter int CREDITS = FSAB_INITIAL_CREDITS
) ();

	localparam int RAND_BASE = 'h1000;
	localparam int CREDIT_LIMIT = 2000;
	localparam int IDLE_LIMIT = 5000;

	logic                   clk0_tb = 1'b0;
	logic                   rst0_tb;
	logic                   fsabo_valid;
	logic [FSAB_REQ_W-1:0]  fsabo_mode;
	logic [FSAB_DID_W-1:0]  fsabo_did;
	logic [FSAB_DID_W-1:0]  fsabo_subdid;
	logic [FSAB_ADDR_W-1:0] fsabo_addr;
	logic [FSAB_LEN_W-1:0]  fsabo_len;
	logic [FSAB_DATA_W-1:0] fsabo_data;
	logic [FSAB_MASK_W-1:0] fsabo_mask;
	logic                   fsabo_credit;
	logic                   fsabi_valid;
	logic [FSAB_DID_W-1:0]  fsabi_did;
	logic [FSAB_DID_W-1:0]  fsabi_subdid;
	logic [FSAB_DATA_W-1:0] fsabi_data;
	logic                   phy_init_done;
	logic                   app_af_wren;
	logic [MIG_CMD_W-1:0]   app_af_cmd;
	logic [FSAB_ADDR_W-1:0] app_af_addr;
	logic                   app_af_afull;
	logic                   app_wdf_wren;
	logic [MIG_WORD_W-1:0]  app_wdf_data;
	logic [MIG_MASK_W-1:0]  app_wdf_mask_data;
	logic                   app_wdf_afull;
	logic                   rd_data_valid;
	logic [MIG_WORD_W-1:0]  rd_data_fifo_out;
	logic                   win_start;
	logic [7:0]             win_len;
	logic                   win_af;
	logic                   win_wdf;
	logic                   afull_on;

	int credits = CREDITS;   // Host side credit count
	int reqs_sent;
	int credit_pulses;
	int early_act;           // Cycles with activity before init
	int run_len;
	int value_errs;
	int other_errs;
	int timeouts;

	logic [7:0]             ref_mem [int];
	logic [FSAB_DATA_W-1:0] want_data [$];
	logic [FSAB_DID_W-1:0]  want_did [$];
	logic [FSAB_DID_W-1:0]  want_sub [$];
	logic [FSAB_DATA_W-1:0] beat_data [FSAB_LEN_MAX];
	logic [FSAB_MASK_W-1:0] beat_mask [FSAB_LEN_MAX];

	fsab_memory #(.CREDITS(CREDITS)) dut0 (.*);

	mig_app_model mig (.*);

	always #5 clk0_tb = ~clk0_tb;

	task automatic check_beat(
		input logic [FSAB_DATA_W-1:0] got_data,
		input logic [FSAB_DATA_W-1:0] exp_data,
		input logic [FSAB_DID_W-1:0]  got_did,
		input logic [FSAB_DID_W-1:0]  exp_did,
		input logic [FSAB_DID_W-1:0]  got_sub,
		input logic [FSAB_DID_W-1:0]  exp_sub
	);
		if (got_data !== exp_data) begin
			value_errs++;
			$display("** Error: fsabi_data got %h expected %h", got_data, exp_data);
		end
		if (got_did !== exp_did) begin
			value_errs++;
			$display("** Error: fsabi_did got %h expected %h", got_did, exp_did);
		end
		if (got_sub !== exp_sub) begin
			value_errs++;
			$display("** Error: fsabi_subdid got %h expected %h", got_sub, exp_sub);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			value_errs++;
			$display("** Error: %s got %h expected %h", what, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("Errors: value %0d, other %0d, timeout %0d", value_errs, other_errs, timeouts);
		if (value_errs + other_errs + timeouts == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	endtask

	// Responses, credits and early activity sampled mid-cycle
	always @(negedge clk0_tb) begin
		if (!phy_init_done && (fsabo_credit || fsabi_valid || app_af_wren || app_wdf_wren))
			early_act++;
		if (fsabo_credit) begin
			credits++;
			credit_pulses++;
		end
		if (fsabi_valid) begin
			run_len++;
			if (want_data.size() == 0) begin
				other_errs++;
				$display("Response beat arrived with no read outstanding");
			end else begin
				check_beat(fsabi_data, want_data.pop_front(), fsabi_did, want_did.pop_front(),
				           fsabi_subdid, want_sub.pop_front());
			end
		end else if (run_len != 0) begin
			check_count("fsabi_valid run length mod 4", run_len % FSAB_LEN_MAX, 0);
			run_len = 0;
		end
	end

	task automatic drive_afull_windows();
		forever begin
			@(posedge clk0_tb);
			win_start <= afull_on && ($urandom_range(0, 11) == 0);
			win_len <= 8'($urandom_range(1, 5));
			win_af <= 1'($urandom_range(0, 1));
			win_wdf <= 1'($urandom_range(0, 1));
		end
	endtask

	task automatic fill_beats(input bit rand_mask);
		int k;
		for (k = 0; k < FSAB_LEN_MAX; k++) begin
			beat_data[k] = {$urandom, $urandom};
			beat_mask[k] = rand_mask ? FSAB_MASK_W'($urandom) : '0;
		end
	endtask

	task automatic send_req(
		input logic [FSAB_REQ_W-1:0]  mode,
		input logic [FSAB_DID_W-1:0]  did,
		input logic [FSAB_DID_W-1:0]  sub,
		input logic [FSAB_ADDR_W-1:0] addr,
		input logic [FSAB_LEN_W-1:0]  len,
		input int                     nbeats,
		input int                     max_gap
	);
		int n;
		int k;
		n = 0;
		while (credits == 0 && n < CREDIT_LIMIT) begin
			@(posedge clk0_tb);
			fsabo_valid <= 1'b0;
			n++;
		end
		if (n >= CREDIT_LIMIT) begin
			timeouts++;
			$display("Timeout waiting for a host credit");
		end else begin
			credits--;
			reqs_sent++;
			for (k = 0; k < nbeats; k++) begin
				if (k > 0 && max_gap > 0)
					repeat ($urandom_range(0, max_gap)) begin
						@(posedge clk0_tb);
						fsabo_valid <= 1'b0;   // Gap between write beats
					end
				@(posedge clk0_tb);
				fsabo_valid <= 1'b1;
				fsabo_mode <= mode;
				fsabo_did <= did;
				fsabo_subdid <= sub;
				fsabo_addr <= addr;
				fsabo_len <= len;
				fsabo_data <= beat_data[k];
				fsabo_mask <= beat_mask[k];
			end
		end
	endtask

	task automatic write_req(input logic [FSAB_DID_W-1:0] did, input logic [FSAB_DID_W-1:0] sub,
	                         input int addr, input int len, input int max_gap);
		int k;
		int b;
		for (k = 0; k < len; k++)
			for (b = 0; b < FSAB_MASK_W; b++)
				if (!beat_mask[k][b])
					ref_mem[addr + 8 * k + b] = beat_data[k][8*b +: 8];
		send_req(FSAB_WRITE, did, sub, FSAB_ADDR_W'(addr), FSAB_LEN_W'(len), len, max_gap);
	endtask

	task automatic read_req(input logic [FSAB_DID_W-1:0] did, input logic [FSAB_DID_W-1:0] sub,
	                        input int addr);
		int k;
		int b;
		logic [FSAB_DATA_W-1:0] w;
		for (k = 0; k < FSAB_LEN_MAX; k++) begin
			for (b = 0; b < FSAB_MASK_W; b++)
				w[8*b +: 8] = ref_mem[addr + 8 * k + b];
			want_data.push_back(w);
			want_did.push_back(did);
			want_sub.push_back(sub);
		end
		send_req(FSAB_READ, did, sub, FSAB_ADDR_W'(addr), FSAB_LEN_W'(FSAB_LEN_MAX), 1, 0);
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(posedge clk0_tb);
		fsabo_valid <= 1'b0;
		while ((want_data.size() != 0 || credit_pulses < reqs_sent) && n < IDLE_LIMIT) begin
			@(posedge clk0_tb);
			n++;
		end
		if (n >= IDLE_LIMIT) begin
			timeouts++;
			$display("Timeout waiting for outstanding requests to complete");
		end else begin
			check_count("fsabo_credit pulses", credit_pulses, reqs_sent);
		end
	endtask

	task automatic init_hold();
		fill_beats(1'b0);
		write_req(4'h1, 4'h0, 'h80, 4, 0);
		@(posedge clk0_tb);
		fsabo_valid <= 1'b0;
		repeat (20) @(posedge clk0_tb);
		check_count("cycles with outputs active before init", early_act, 0);
		phy_init_done <= 1'b1;
		wait_idle();
	endtask

	task automatic full_write_read();
		fill_beats(1'b0);
		write_req(4'h2, 4'h3, 'h100, 4, 0);
		read_req(4'h5, 4'h9, 'h100);
		wait_idle();
	endtask

	task automatic partial_writes();
		fill_beats(1'b0);
		write_req(4'h1, 4'h1, 'h200, 4, 0);   // Known background
		fill_beats(1'b0);
		write_req(4'h1, 4'h2, 'h220, 4, 0);
		fill_beats(1'b1);
		write_req(4'h3, 4'h4, 'h200, 1, 0);
		fill_beats(1'b1);
		write_req(4'h3, 4'h5, 'h220, 3, 1);
		read_req(4'h6, 4'h7, 'h200);
		read_req(4'h6, 4'h8, 'h220);
		wait_idle();
	endtask

	task automatic back_to_back();
		int i;
		for (i = 0; i < CREDITS; i++) begin
			if (i % 2 == 0) begin
				fill_beats(1'b0);
				write_req(FSAB_DID_W'(i), FSAB_DID_W'(i), 'h300, 4, 0);
			end else begin
				read_req(FSAB_DID_W'(i), FSAB_DID_W'(15 - i), 'h300);
			end
		end
		wait_idle();
	endtask

	task automatic random_mix();
		int i;
		int blk;
		for (blk = 0; blk < 8; blk++) begin
			fill_beats(1'b0);
			write_req(4'h0, FSAB_DID_W'(blk), RAND_BASE + 32 * blk, 4, 1);
		end
		afull_on <= 1'b1;
		for (i = 0; i < 40; i++) begin
			blk = $urandom_range(0, 7);
			if ($urandom_range(0, 1) == 1) begin
				fill_beats(1'b1);
				write_req(FSAB_DID_W'($urandom), FSAB_DID_W'($urandom), RAND_BASE + 32 * blk,
				          $urandom_range(1, 4), 2);
			end else begin
				read_req(FSAB_DID_W'($urandom), FSAB_DID_W'($urandom), RAND_BASE + 32 * blk);
			end
		end
		wait_idle();
		afull_on <= 1'b0;
	endtask

	initial begin
		void'($urandom(85677));
		rst0_tb = 1'b1;
		fsabo_valid = 1'b0;
		fsabo_mode = FSAB_READ;
		fsabo_did = '0;
		fsabo_subdid = '0;
		fsabo_addr = '0;
		fsabo_len = '0;
		fsabo_data = '0;
		fsabo_mask = '0;
		phy_init_done = 1'b0;
		win_start = 1'b0;
		win_len = '0;
		win_af = 1'b0;
		win_wdf = 1'b0;
		afull_on = 1'b0;
		fork
			drive_afull_windows();
		join_none
		repeat (16) @(posedge clk0_tb);
		rst0_tb <= 1'b0;
		init_hold();
		full_write_read();
		partial_writes();
		back_to_back();
		random_mix();
		finish_run();
	end

endmodule

// File: verif/mig_app_model.sv
`timescale 1ns/100ps

module mig_app_model import fsab_mem_pkg::*; #(
	parameter int RD_LAT = 5
) (
	input  logic                   clk0_tb,
	input  logic                   rst0_tb,
	input  logic                   app_af_wren,
	input  logic [MIG_CMD_W-1:0]   app_af_cmd,
	input  logic [FSAB_ADDR_W-1:0] app_af_addr,
	input  logic                   app_wdf_wren,
	input  logic [MIG_WORD_W-1:0]  app_wdf_data,
	input  logic [MIG_MASK_W-1:0]  app_wdf_mask_data,
	input  logic                   win_start,
	input  logic [7:0]             win_len,
	input  logic                   win_af,
	input  logic                   win_wdf,
	output logic                   app_af_afull,
	output logic                   app_wdf_afull,
	output logic                   rd_data_valid,
	output logic [MIG_WORD_W-1:0]  rd_data_fifo_out
);

	logic [MIG_WORD_W-1:0] mem [int];   // Indexed by byte address / 16
	logic [MIG_WORD_W-1:0] rd_words [$];
	int                    rd_due [$];   // Cycle each queued word may return
	int                    cyc;
	int                    wr_next;      // Word index for the next write word
	int                    idx;
	int                    k;
	logic [MIG_WORD_W-1:0] w;
	logic [7:0]            af_cnt;
	logic [7:0]            wdf_cnt;

	assign app_af_afull = (af_cnt != 0);
	assign app_wdf_afull = (wdf_cnt != 0);

	function automatic logic [MIG_WORD_W-1:0] word_at(input int i);
		logic [31:0] a;
		a = i;
		if (mem.exists(i))
			return mem[i];
		return {~a, a ^ 32'h5a5a_a5a5, a + 32'h0123_4567, a};   // Fill for unwritten words
	endfunction

	always @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			rd_data_valid <= 1'b0;
			rd_data_fifo_out <= '0;
			af_cnt <= '0;
			wdf_cnt <= '0;
			cyc <= 0;
			wr_next <= 0;
		end else begin
			cyc <= cyc + 1;
			if (win_start && win_af)
				af_cnt <= win_len;
			else if (af_cnt != 0)
				af_cnt <= af_cnt - 1'b1;
			if (win_start && win_wdf)
				wdf_cnt <= win_len;
			else if (wdf_cnt != 0)
				wdf_cnt <= wdf_cnt - 1'b1;
			idx = app_af_wren ? int'(app_af_addr >> 4) : wr_next;
			if (app_wdf_wren) begin
				w = word_at(idx);
				for (k = 0; k < MIG_MASK_W; k++)
					if (!app_wdf_mask_data[k])
						w[8*k +: 8] = app_wdf_data[8*k +: 8];   // Set mask bit keeps old byte
				mem[idx] = w;
				wr_next <= idx + 1;
			end else if (app_af_wren) begin
				wr_next <= idx;
			end
			if (app_af_wren && app_af_cmd == MIG_READ)
				for (k = 0; k < MIG_BURST_WORDS; k++) begin
					rd_words.push_back(word_at(idx + k));   // Data as of the command
					rd_due.push_back(cyc + RD_LAT);
				end
			if (rd_due.size() != 0 && rd_due[0] <= cyc) begin
				rd_data_valid <= 1'b1;
				rd_data_fifo_out <= rd_words.pop_front();
				void'(rd_due.pop_front());
			end else begin
				rd_data_valid <= 1'b0;
			end
		end
	end

endmodule
